//--- common/chitchat_proto_pkg.sv
/*
 * Chitchat wire protocol: frame layout, control words and station identity.
 * Imported by the transmit and receive ends of the link.
 */
package chitchat_proto_pkg;

   // --------------------
   // Frame layout
   // --------------------
   // Word 0 comma, 1 identity, 2-3 rev_id, 4 frame counter,
   // 5 loopback counter, 6-7 data0, 8-9 data1, 10 checksum
   localparam int FRAME_WORDS = 11;

   // K28.5 in the low byte, only the low k flag set
   localparam logic [15:0] COMMA_WORD = 16'h00bc;
   localparam logic [1:0]  COMMA_K    = 2'b01;

   localparam logic [3:0] PROTOCOL_VER = 4'd1;

   // Receive cycles without a comma before loss of signal
   localparam int LOS_TIMEOUT = 64;

   // --------------------
   // Frame contents
   // --------------------
   typedef struct packed {
      logic [31:0] data1;
      logic [31:0] data0;
   } tx_payload_t;

   typedef struct packed {
      logic [3:0]  protocol_ver;
      logic [2:0]  gateware_type;
      logic [2:0]  location;
      logic [31:0] rev_id;
   } id_fields_t;

endpackage

//--- common/chitchat_status_pkg.sv
/*
 * Receive status and the payload bundles carried across clock domains.
 */
package chitchat_status_pkg;

   typedef struct packed {
      logic ver_mismatch;
      logic unexpected_comma;
      logic bad_checksum;
   } fault_t;

   // frame_drop sits in the low bit and tells a drop from good data
   typedef struct packed {
      logic [31:0] data1;
      logic [31:0] data0;
      logic        frame_drop;
   } rx_payload_t;

   typedef struct packed {
      logic [15:0] frame_counter;
      fault_t      fault;
   } lb_status_t;

   // Remote counter to echo back, and our own counter as echoed
   typedef struct packed {
      logic [15:0] frame_counter;
      logic [15:0] lback_frame_counter;
   } lback_counters_t;

endpackage

//--- rtl/data_xdomain.sv
/*
 * Gated clock crossing. A source gate holds the payload and flips a toggle,
 * the destination syncs the toggle and strobes gate_out with the payload.
 */
`timescale 1ns/1ps

module data_xdomain #(
   parameter type payload_t = logic [7:0]
) (
   input  logic     clk_in,
   input  logic     clk_out,
   input  logic     reset,
   input  logic     gate_in,
   input  payload_t data_in,
   output logic     gate_out,
   output payload_t data_out
);

   payload_t   data_hold;
   logic       toggle_in;
   logic [2:0] toggle_sync;   // Two sync stages plus one for edge detect
   logic       toggle_edge;

   // --------------------
   // Source domain
   // --------------------
   always_ff @(posedge clk_in) begin
      if (reset) begin
         toggle_in <= 1'b0;
      end else if (gate_in) begin
         toggle_in <= ~toggle_in;
      end
   end

   always_ff @(posedge clk_in) begin
      if (gate_in) begin
         data_hold <= data_in;
      end
   end

   // --------------------
   // Destination domain
   // --------------------
   assign toggle_edge = toggle_sync[2] ^ toggle_sync[1];

   always_ff @(posedge clk_out) begin
      if (reset) begin
         toggle_sync <= '0;
         gate_out    <= 1'b0;
      end else begin
         toggle_sync <= {toggle_sync[1:0], toggle_in};
         gate_out    <= toggle_edge;
      end
   end

   // data_hold has been stable for at least two destination cycles here
   always_ff @(posedge clk_out) begin
      if (reset) begin
         data_out <= '0;
      end else if (toggle_edge) begin
         data_out <= data_hold;
      end
   end

   // No new gate until the destination has taken the held payload
   assert property (@(posedge clk_in) disable iff (reset)
      (toggle_in != toggle_sync[2]) |=> $stable(data_hold));

endmodule

//--- chitchat_tx/chitchat_tx.sv
/*
 * Chitchat transmitter. Sends commas when idle and fixed-length frames while
 * enabled, one 16-bit word per cycle, with an additive checksum last.
 */
`timescale 1ns/1ps

module chitchat_tx #(
   parameter logic [31:0] REV_ID        = 32'h0,
   parameter logic [2:0]  GATEWARE_TYPE = 3'd0
) (
   input  logic                            gtx_tx_clk,
   input  logic                            reset,
   input  logic                            transmit_en,
   input  logic [2:0]                      location,
   input  chitchat_proto_pkg::tx_payload_t payload,
   input  logic [15:0]                     loopback_frame_counter,
   output logic                            tx_send,
   output logic [15:0]                     local_frame_counter,
   output logic [15:0]                     gtx_d,
   output logic [1:0]                      gtx_k
);

   import chitchat_proto_pkg::*;

   localparam logic [3:0] LAST_IDX = 4'(FRAME_WORDS - 1);

   logic [3:0]  idx;         // Index of the word on gtx_d
   logic        in_frame;
   logic        start;
   logic [3:0]  next_idx;
   logic [15:0] next_word;
   logic [15:0] csum;
   tx_payload_t payload_l;
   id_fields_t  ids_l;
   logic [15:0] lback_l;

   assign start    = transmit_en && (!in_frame || idx == LAST_IDX);
   assign next_idx = idx + 4'd1;

   // Word after the current one, from the fields latched at frame start
   always_comb begin
      case (next_idx)
         4'd1:    next_word = {ids_l.protocol_ver, ids_l.gateware_type, ids_l.location, 6'd0};
         4'd2:    next_word = ids_l.rev_id[31:16];
         4'd3:    next_word = ids_l.rev_id[15:0];
         4'd4:    next_word = local_frame_counter;
         4'd5:    next_word = lback_l;
         4'd6:    next_word = payload_l.data0[31:16];
         4'd7:    next_word = payload_l.data0[15:0];
         4'd8:    next_word = payload_l.data1[31:16];
         4'd9:    next_word = payload_l.data1[15:0];
         default: next_word = csum;
      endcase
   end

   always_ff @(posedge gtx_tx_clk) begin
      if (reset) begin
         in_frame            <= 1'b0;
         idx                 <= '0;
         tx_send             <= 1'b0;
         local_frame_counter <= '0;
         csum                <= '0;
         gtx_d               <= COMMA_WORD;
         gtx_k               <= COMMA_K;
      end else begin
         tx_send <= start;
         if (start) begin
            in_frame            <= 1'b1;
            idx                 <= '0;
            local_frame_counter <= local_frame_counter + 16'd1;
            csum                <= '0;
            gtx_d               <= COMMA_WORD;
            gtx_k               <= COMMA_K;
         end else if (in_frame && idx != LAST_IDX) begin
            idx   <= next_idx;
            gtx_d <= next_word;
            gtx_k <= 2'b00;
            // Sum covers words 1 to 9
            if (next_idx != LAST_IDX) begin
               csum <= csum + next_word;
            end
         end else begin
            in_frame <= 1'b0;
            idx      <= '0;
            gtx_d    <= COMMA_WORD;
            gtx_k    <= COMMA_K;
         end
      end
   end

   always_ff @(posedge gtx_tx_clk) begin
      if (start) begin
         payload_l <= payload;
         lback_l   <= loopback_frame_counter;
         ids_l     <= '{protocol_ver: PROTOCOL_VER, gateware_type: GATEWARE_TYPE,
                        location: location, rev_id: REV_ID};
      end
   end

   assert property (@(posedge gtx_tx_clk) disable iff (reset)
      (gtx_k != 2'b00) |-> (gtx_d == COMMA_WORD && gtx_k == COMMA_K));

endmodule

//--- chitchat_rx/chitchat_rx.sv
/*
 * Chitchat receiver. Aligns on the comma, collects frame words, checks the
 * checksum and version, and tracks faults and loss of signal.
 */
`timescale 1ns/1ps

module chitchat_rx (
   input  logic                            gtx_rx_clk,
   input  logic                            reset,
   input  logic [15:0]                     gtx_d,
   input  logic [1:0]                      gtx_k,
   output logic                            rx_valid,
   output logic                            frame_drop,
   output logic                            los,
   output chitchat_status_pkg::fault_t     fault,
   output logic [15:0]                     fault_cnt,
   output logic [15:0]                     frame_counter,
   output logic [15:0]                     loopback_frame_counter,
   output chitchat_proto_pkg::id_fields_t  ids,
   output chitchat_proto_pkg::tx_payload_t payload
);

   import chitchat_proto_pkg::*;

   localparam int         SR_W     = (FRAME_WORDS - 2) * 16;
   localparam int         LOS_W    = $clog2(LOS_TIMEOUT);
   localparam logic [3:0] LAST_IDX = 4'(FRAME_WORDS - 1);

   logic             is_comma;
   logic [3:0]       idx;        // Index of the next expected word, 0 when idle
   logic [SR_W-1:0]  frame_sr;   // Words 1 to 9, word 1 at the top
   logic [15:0]      csum;
   logic             frame_end;
   logic             csum_bad;
   logic             ver_bad;
   logic             comma_fault;
   logic             end_fault;
   logic [LOS_W-1:0] los_timer;

   assign is_comma    = gtx_k == COMMA_K && gtx_d == COMMA_WORD;
   assign frame_end   = !is_comma && idx == LAST_IDX;
   assign csum_bad    = csum != gtx_d;
   assign ver_bad     = frame_sr[SR_W-1 -: 4] != PROTOCOL_VER;
   assign comma_fault = is_comma && idx > 4'd1;
   assign end_fault   = frame_end && (csum_bad || ver_bad);

   // --------------------
   // Frame control
   // --------------------
   always_ff @(posedge gtx_rx_clk) begin
      if (reset) begin
         idx        <= '0;
         csum       <= '0;
         rx_valid   <= 1'b0;
         frame_drop <= 1'b0;
         fault      <= '0;
         fault_cnt  <= '0;
      end else begin
         rx_valid   <= frame_end && !end_fault;
         frame_drop <= comma_fault || end_fault;
         if (is_comma) begin
            idx  <= 4'd1;
            csum <= '0;
         end else if (frame_end) begin
            idx <= '0;
         end else if (idx != '0) begin
            idx  <= idx + 4'd1;
            csum <= csum + gtx_d;
         end
         if (comma_fault || end_fault) begin
            fault <= '{ver_mismatch: end_fault && ver_bad, unexpected_comma: comma_fault,
                       bad_checksum: end_fault && csum_bad};
            if (fault_cnt != '1) begin
               fault_cnt <= fault_cnt + 16'd1;
            end
         end
      end
   end

   // --------------------
   // Field capture
   // --------------------
   always_ff @(posedge gtx_rx_clk) begin
      if (!is_comma && idx != '0 && idx != LAST_IDX) begin
         frame_sr <= {frame_sr[SR_W-17:0], gtx_d};
      end
      if (frame_end && !end_fault) begin
         ids.protocol_ver       <= frame_sr[143:140];
         ids.gateware_type      <= frame_sr[139:137];
         ids.location           <= frame_sr[136:134];
         ids.rev_id             <= frame_sr[127:96];
         frame_counter          <= frame_sr[95:80];
         loopback_frame_counter <= frame_sr[79:64];
         payload.data0          <= frame_sr[63:32];
         payload.data1          <= frame_sr[31:0];
      end
   end

   // Loss of signal
   always_ff @(posedge gtx_rx_clk) begin
      if (reset) begin
         los       <= 1'b1;
         los_timer <= '0;
      end else if (is_comma) begin
         los       <= 1'b0;
         los_timer <= '0;
      end else if (los_timer == LOS_W'(LOS_TIMEOUT - 1)) begin
         los <= 1'b1;
      end else begin
         los_timer <= los_timer + 1'b1;
      end
   end

   assert property (@(posedge gtx_rx_clk) disable iff (reset) !(rx_valid && frame_drop));

endmodule

//--- rtl/chitchat_txrx_wrap.sv
/*
 * Chitchat link top. Connects the transmitter and receiver to the transceiver
 * words and crosses all user, status and latency signals into their domains.
 */
`timescale 1ns/1ps

module chitchat_txrx_wrap #(
   parameter logic [31:0] REV_ID           = 32'h0,
   parameter logic [2:0]  TX_GATEWARE_TYPE = 3'd0
) (
   input  logic        reset,

   // Data interface
   input  logic        tx_clk,
   input  logic        tx_transmit_en,
   input  logic        tx_valid,
   input  logic [2:0]  tx_location,
   input  logic [31:0] tx_data0,
   input  logic [31:0] tx_data1,
   input  logic        rx_clk,
   output logic        rx_valid,
   output logic [31:0] rx_data0,
   output logic [31:0] rx_data1,
   output logic        ccrx_frame_drop,

   // Local bus interface
   input  logic        lb_clk,
   output logic [15:0] txrx_latency,
   output logic [15:0] rx_frame_counter,
   output logic [3:0]  rx_protocol_ver,
   output logic [2:0]  rx_gateware_type,
   output logic [2:0]  rx_location,
   output logic [31:0] rx_rev_id,
   output logic [2:0]  ccrx_fault,
   output logic [15:0] ccrx_fault_cnt,
   output logic        ccrx_los,

   // Transceiver interface
   input  logic        gtx_tx_clk,
   input  logic        gtx_rx_clk,
   output logic [15:0] gtx_tx_d,
   output logic [1:0]  gtx_tx_k,
   input  logic [15:0] gtx_rx_d,
   input  logic [1:0]  gtx_rx_k
);

   import chitchat_proto_pkg::*;
   import chitchat_status_pkg::*;

   tx_payload_t     tx_pack, tx_pack_tgtx, rx_data_rgtx;
   logic            tx_transmit_en_tgtx;
   logic [2:0]      tx_location_tgtx;
   logic [15:0]     local_frame_counter_tgtx;
   logic [15:0]     txrx_latency_tgtx;
   lback_counters_t lback_rgtx, lback_tgtx;
   logic            lback_valid_tgtx;
   logic            rx_valid_rgtx, frame_drop_rgtx, rx_strobe_rgtx;
   logic            los_rgtx;
   fault_t          fault_rgtx;
   logic [15:0]     fault_cnt_rgtx;
   id_fields_t      ids_rgtx, ids_lb;
   rx_payload_t     rx_pack_rgtx, rx_pack;
   logic            rx_strobe_rx;
   lb_status_t      lb_pack;

   // --------------------
   // Transmit side
   // --------------------
   assign tx_pack = '{data1: tx_data1, data0: tx_data0};

   // Latches user data on tx_valid, the gate out is not needed
   data_xdomain #(.payload_t(tx_payload_t)) i_tx_sync (
      .clk_in   (tx_clk),
      .clk_out  (gtx_tx_clk),
      .reset    (reset),
      .gate_in  (tx_valid),
      .data_in  (tx_pack),
      .gate_out (),
      .data_out (tx_pack_tgtx)
   );

   always_ff @(posedge gtx_tx_clk) begin
      if (reset) begin
         tx_transmit_en_tgtx <= 1'b0;
      end else begin
         tx_transmit_en_tgtx <= tx_transmit_en;
      end
      tx_location_tgtx <= tx_location;
   end

   chitchat_tx #(
      .REV_ID        (REV_ID),
      .GATEWARE_TYPE (TX_GATEWARE_TYPE)
   ) i_chitchat_tx (
      .gtx_tx_clk             (gtx_tx_clk),
      .reset                  (reset),
      .transmit_en            (tx_transmit_en_tgtx),
      .location               (tx_location_tgtx),
      .payload                (tx_pack_tgtx),
      .loopback_frame_counter (lback_tgtx.frame_counter),
      .tx_send                (),
      .local_frame_counter    (local_frame_counter_tgtx),
      .gtx_d                  (gtx_tx_d),
      .gtx_k                  (gtx_tx_k)
   );

   data_xdomain #(.payload_t(lback_counters_t)) i_latency_sync (
      .clk_in   (gtx_rx_clk),
      .clk_out  (gtx_tx_clk),
      .reset    (reset),
      .gate_in  (rx_valid_rgtx),
      .data_in  (lback_rgtx),
      .gate_out (lback_valid_tgtx),
      .data_out (lback_tgtx)
   );

   // Loopback latency in frames
   always_ff @(posedge gtx_tx_clk) begin
      if (lback_valid_tgtx) begin
         txrx_latency_tgtx <= local_frame_counter_tgtx - lback_tgtx.lback_frame_counter;
      end
   end

   // --------------------
   // Receive side
   // --------------------
   chitchat_rx i_chitchat_rx (
      .gtx_rx_clk             (gtx_rx_clk),
      .reset                  (reset),
      .gtx_d                  (gtx_rx_d),
      .gtx_k                  (gtx_rx_k),
      .rx_valid               (rx_valid_rgtx),
      .frame_drop             (frame_drop_rgtx),
      .los                    (los_rgtx),
      .fault                  (fault_rgtx),
      .fault_cnt              (fault_cnt_rgtx),
      .frame_counter          (lback_rgtx.frame_counter),
      .loopback_frame_counter (lback_rgtx.lback_frame_counter),
      .ids                    (ids_rgtx),
      .payload                (rx_data_rgtx)
   );

   assign rx_strobe_rgtx = rx_valid_rgtx | frame_drop_rgtx;
   assign rx_pack_rgtx   = '{data1: rx_data_rgtx.data1, data0: rx_data_rgtx.data0,
                             frame_drop: frame_drop_rgtx};

   data_xdomain #(.payload_t(rx_payload_t)) i_rx_sync (
      .clk_in   (gtx_rx_clk),
      .clk_out  (rx_clk),
      .reset    (reset),
      .gate_in  (rx_strobe_rgtx),
      .data_in  (rx_pack_rgtx),
      .gate_out (rx_strobe_rx),
      .data_out (rx_pack)
   );

   // Demux the crossed strobe into data valid and drop
   assign rx_valid        = rx_strobe_rx & ~rx_pack.frame_drop;
   assign ccrx_frame_drop = rx_strobe_rx & rx_pack.frame_drop;
   assign rx_data0        = rx_pack.data0;
   assign rx_data1        = rx_pack.data1;

   data_xdomain #(.payload_t(lb_status_t)) i_lb_sync (
      .clk_in   (gtx_rx_clk),
      .clk_out  (lb_clk),
      .reset    (reset),
      .gate_in  (rx_strobe_rgtx),
      .data_in  ('{frame_counter: lback_rgtx.frame_counter, fault: fault_rgtx}),
      .gate_out (),
      .data_out (lb_pack)
   );

   assign rx_frame_counter = lb_pack.frame_counter;
   assign ccrx_fault       = lb_pack.fault;

   // --------------------
   // Local bus status
   // --------------------
   always_ff @(posedge lb_clk) begin
      if (reset) begin
         ccrx_los       <= 1'b1;
         ccrx_fault_cnt <= '0;
      end else begin
         ccrx_los       <= los_rgtx;
         ccrx_fault_cnt <= fault_cnt_rgtx;
      end
      ids_lb       <= ids_rgtx;
      txrx_latency <= txrx_latency_tgtx;   // Settles once the link runs
   end

   assign rx_protocol_ver  = ids_lb.protocol_ver;
   assign rx_gateware_type = ids_lb.gateware_type;
   assign rx_location      = ids_lb.location;
   assign rx_rev_id        = ids_lb.rev_id;

endmodule

//--- verification/chitchat_tb.sv
/*
 * Testbench for the chitchat link. Loops the transceiver words back through
 * a fault mux and checks delivery, identity, faults, LOS and latency.
 */
`timescale 1ns/1ps

module chitchat_tb;

   import chitchat_proto_pkg::*;
   import chitchat_status_pkg::*;

   localparam logic [31:0] REV_ID           = 32'hc4a7_0105;
   localparam logic [2:0]  TX_GATEWARE_TYPE = 3'd2;
   localparam int          GTX_PERIOD       = 40;
   localparam logic [15:0] FORCED_WORD      = 16'h5555;
   // Each frame echoes the counter of the frame two before it, and the
   // result is taken while the next frame is already going out
   localparam int          MAX_LATENCY      = 3;

   logic        reset;
   logic        tx_clk, rx_clk, lb_clk, gtx_tx_clk;
   logic        tx_transmit_en, tx_valid;
   logic [2:0]  tx_location;
   logic [31:0] tx_data0, tx_data1;
   logic        rx_valid, ccrx_frame_drop, ccrx_los;
   logic [31:0] rx_data0, rx_data1, rx_rev_id;
   logic [15:0] txrx_latency, rx_frame_counter, ccrx_fault_cnt;
   logic [3:0]  rx_protocol_ver;
   logic [2:0]  rx_gateware_type, rx_location, ccrx_fault;
   logic [15:0] gtx_tx_d, gtx_rx_d;
   logic [1:0]  gtx_tx_k, gtx_rx_k;

   // Loopback control and checker state
   logic        force_idle, flip_armed, flip_bit;
   logic        drop_allowed, quiet, counting;
   int          word_pos = 0;
   int          seed = 10;
   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          drop_count = 0;
   logic [63:0] sent[$];
   logic [63:0] last_rx;
   logic        have_last = 1'b0;

   // Direct loopback, with a forced word or one flipped bit when asked
   assign gtx_rx_d = force_idle ? FORCED_WORD : gtx_tx_d ^ {15'd0, flip_bit};
   assign gtx_rx_k = force_idle ? 2'b00 : gtx_tx_k;

   chitchat_txrx_wrap #(
      .REV_ID           (REV_ID),
      .TX_GATEWARE_TYPE (TX_GATEWARE_TYPE)
   ) dut (
      .reset            (reset),
      .tx_clk           (tx_clk),
      .tx_transmit_en   (tx_transmit_en),
      .tx_valid         (tx_valid),
      .tx_location      (tx_location),
      .tx_data0         (tx_data0),
      .tx_data1         (tx_data1),
      .rx_clk           (rx_clk),
      .rx_valid         (rx_valid),
      .rx_data0         (rx_data0),
      .rx_data1         (rx_data1),
      .ccrx_frame_drop  (ccrx_frame_drop),
      .lb_clk           (lb_clk),
      .txrx_latency     (txrx_latency),
      .rx_frame_counter (rx_frame_counter),
      .rx_protocol_ver  (rx_protocol_ver),
      .rx_gateware_type (rx_gateware_type),
      .rx_location      (rx_location),
      .rx_rev_id        (rx_rev_id),
      .ccrx_fault       (ccrx_fault),
      .ccrx_fault_cnt   (ccrx_fault_cnt),
      .ccrx_los         (ccrx_los),
      .gtx_tx_clk       (gtx_tx_clk),
      .gtx_rx_clk       (gtx_tx_clk),
      .gtx_tx_d         (gtx_tx_d),
      .gtx_tx_k         (gtx_tx_k),
      .gtx_rx_d         (gtx_rx_d),
      .gtx_rx_k         (gtx_rx_k)
   );

   // --------------------
   // Clocks
   // --------------------
   initial begin
      gtx_tx_clk = 1'b0;
      forever #(GTX_PERIOD / 2) gtx_tx_clk = ~gtx_tx_clk;
   end

   initial begin
      tx_clk = 1'b0;
      forever #15 tx_clk = ~tx_clk;
   end

   initial begin
      rx_clk = 1'b0;
      forever #17 rx_clk = ~rx_clk;
   end

   initial begin
      lb_clk = 1'b0;
      forever #25 lb_clk = ~lb_clk;
   end

   // --------------------
   // Checkers
   // --------------------
   task automatic count_error(input string msg);
      errors++;
      $display("error %0t: %s", $time, msg);
   endtask

   // Word position in the transmitted frame, comma is word 0
   always @(negedge gtx_tx_clk) begin
      if (gtx_tx_k != 2'b00) begin
         word_pos = 0;
      end else begin
         word_pos = word_pos + 1;
      end
      // Word 6 is the upper half of data0
      flip_bit = flip_armed && word_pos == 6;
      if (flip_bit) begin
         flip_armed = 1'b0;
      end
   end

   // Delivered data is the oldest value not yet seen, or a repeat of the last
   always @(negedge rx_clk) begin
      if (rx_valid) begin
         checks++;
         if (sent.size() > 0 && {rx_data1, rx_data0} == sent[0]) begin
            last_rx   = sent.pop_front();
            have_last = 1'b1;
         end else begin
            assert (have_last && {rx_data1, rx_data0} == last_rx)
            else count_error($sformatf("rx data %h, expected %h", {rx_data1, rx_data0},
                                       sent.size() > 0 ? sent[0] : last_rx));
         end
      end
      if (ccrx_frame_drop) begin
         drop_count++;
      end
   end

   assert property (@(posedge rx_clk) disable iff (reset) ccrx_frame_drop |-> drop_allowed)
   else count_error("frame drop without an injected fault");

   assert property (@(posedge rx_clk) disable iff (reset) rx_valid |-> !quiet)
   else count_error("rx_valid while transmission is disabled");

   assert property (@(posedge lb_clk) disable iff (reset || !counting)
      rx_frame_counter >= $past(rx_frame_counter))
   else count_error($sformatf("rx_frame_counter went back to %0d", rx_frame_counter));

   // --------------------
   // Stimulus helpers
   // --------------------
   task automatic report_timeout(input string what);
      errors++;
      $display("Timeout while waiting for %s", what);
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests++;
      $display("Test %0d %-24s %s", tests, name, errors == errors_before ? "passed" : "failed");
   endtask

   task automatic send_data();
      @(negedge tx_clk);
      tx_data0 = $random(seed);
      tx_data1 = $random(seed);
      tx_valid = 1'b1;
      sent.push_back({tx_data1, tx_data0});
      @(negedge tx_clk);
      tx_valid = 1'b0;
   endtask

   task automatic wait_rx_valid(input int frames, input string what);
      int seen;
      int cycles;
      seen   = 0;
      cycles = 0;
      while (seen < frames && cycles < frames * 40 + 100) begin
         @(negedge rx_clk);
         cycles++;
         if (rx_valid) begin
            seen++;
         end
      end
      if (seen < frames) begin
         report_timeout(what);
      end
   endtask

   task automatic wait_drop(input string what);
      int cycles;
      cycles = 0;
      do begin
         @(negedge rx_clk);
         cycles++;
      end while (!ccrx_frame_drop && cycles < 200);
      if (!ccrx_frame_drop) begin
         report_timeout(what);
      end
   endtask

   task automatic wait_los(input logic level, input string what);
      int cycles;
      cycles = 0;
      do begin
         @(negedge lb_clk);
         cycles++;
      end while (ccrx_los !== level && cycles < 4 * LOS_TIMEOUT);
      if (ccrx_los !== level) begin
         report_timeout(what);
      end
   endtask

   // Consecutive comma words on the transmit side
   task automatic wait_idle_words(input int words);
      int run;
      int cycles;
      run    = 0;
      cycles = 0;
      while (run < words && cycles < 10 * words) begin
         @(negedge gtx_tx_clk);
         cycles++;
         run = (gtx_tx_k != 2'b00) ? run + 1 : 0;
      end
      if (run < words) begin
         report_timeout("idle commas after disable");
      end
   endtask

   // Falling edge with a comma word on the transmit side
   task automatic wait_comma();
      int cycles;
      cycles = 0;
      do begin
         @(negedge gtx_tx_clk);
         cycles++;
      end while (gtx_tx_k == 2'b00 && cycles < 4 * FRAME_WORDS);
      if (gtx_tx_k == 2'b00) begin
         report_timeout("a comma word on the link");
      end
   endtask

   task automatic wait_sent_empty();
      int cycles;
      cycles = 0;
      while (sent.size() > 0 && cycles < 400) begin
         @(negedge rx_clk);
         cycles++;
      end
      if (sent.size() > 0) begin
         report_timeout($sformatf("%0d undelivered data words", sent.size()));
      end
   endtask

   task automatic wait_counter_advance(input int frames);
      logic [15:0] start;
      int          cycles;
      cycles = 0;
      @(negedge lb_clk);
      start = rx_frame_counter;
      while (rx_frame_counter - start < 16'(frames) && cycles < frames * 20 + 100) begin
         @(negedge lb_clk);
         cycles++;
      end
      if (rx_frame_counter - start < 16'(frames)) begin
         report_timeout("frame counter to advance");
      end
   endtask

   // --------------------
   // Test sequence
   // --------------------
   initial begin
      int          mark;
      int          i;
      int          drops_before;
      logic [15:0] cnt_before;
      logic [15:0] latency;
      fault_t      fault;
      time         t_force;

      reset          = 1'b1;
      tx_transmit_en = 1'b0;
      tx_valid       = 1'b0;
      tx_location    = 3'd5;
      tx_data0       = '0;
      tx_data1       = '0;
      force_idle     = 1'b0;
      flip_armed     = 1'b0;
      flip_bit       = 1'b0;
      drop_allowed   = 1'b0;
      quiet          = 1'b0;
      counting       = 1'b0;
      repeat (2) @(negedge gtx_tx_clk);
      reset = 1'b0;

      // First payload in place before any frame leaves
      send_data();
      repeat (10) @(negedge tx_clk);
      tx_transmit_en = 1'b1;
      wait_rx_valid(1, "first frame");
      counting = 1'b1;

      // Data delivery, spaced wider than two frames
      mark = errors;
      for (i = 0; i < 8; i++) begin
         send_data();
         repeat (40) @(negedge tx_clk);
      end
      wait_sent_empty();
      report_test("data delivery", mark);

      mark = errors;
      wait_los(1'b0, "link up");
      repeat (4) @(negedge lb_clk);
      checks++;
      assert (rx_rev_id == REV_ID && rx_gateware_type == TX_GATEWARE_TYPE &&
              rx_location == tx_location && rx_protocol_ver == 4'd1 && !ccrx_los)
      else count_error($sformatf("ids rev %h type %0d location %0d version %0d los %b",
                                 rx_rev_id, rx_gateware_type, rx_location,
                                 rx_protocol_ver, ccrx_los));
      report_test("identity fields", mark);

      mark = errors;
      wait_counter_advance(8);
      report_test("frame counter", mark);

      // One flipped data bit
      mark = errors;
      @(negedge lb_clk);
      cnt_before   = ccrx_fault_cnt;
      drops_before = drop_count;
      drop_allowed = 1'b1;
      @(posedge gtx_tx_clk);
      flip_armed = 1'b1;
      wait_drop("drop after bit flip");
      wait_rx_valid(1, "frame after bit flip");
      repeat (4) @(negedge lb_clk);
      drop_allowed = 1'b0;
      fault = ccrx_fault;
      checks++;
      assert (drop_count == drops_before + 1 && ccrx_fault_cnt == cnt_before + 16'd1)
      else count_error($sformatf("%0d drops, fault count %0d after %0d",
                                 drop_count - drops_before, ccrx_fault_cnt, cnt_before));
      checks++;
      assert (fault.bad_checksum && !fault.ver_mismatch && !fault.unexpected_comma)
      else count_error($sformatf("fault flags %b, expected bad checksum only", ccrx_fault));
      report_test("fault injection", mark);

      // Loss of signal, forced from just after a received comma
      mark = errors;
      drop_allowed = 1'b1;
      wait_comma();
      @(negedge gtx_tx_clk);
      force_idle = 1'b1;
      t_force    = $time;
      wait_los(1'b1, "loss of signal");
      checks++;
      assert ($time - t_force >= LOS_TIMEOUT * GTX_PERIOD)
      else count_error($sformatf("LOS after %0t, before the timeout", $time - t_force));
      @(negedge gtx_tx_clk);
      force_idle = 1'b0;
      wait_los(1'b0, "signal recovery");
      wait_rx_valid(1, "frame after recovery");
      repeat (4) @(negedge lb_clk);
      drop_allowed = 1'b0;
      @(negedge tx_clk);
      tx_transmit_en = 1'b0;
      wait_idle_words(2 * FRAME_WORDS);
      quiet = 1'b1;
      repeat (20 * FRAME_WORDS) @(negedge gtx_tx_clk);
      quiet = 1'b0;
      report_test("loss of signal, disable", mark);

      mark = errors;
      @(negedge tx_clk);
      tx_transmit_en = 1'b1;
      wait_rx_valid(4, "frames after enable");
      repeat (4) @(negedge lb_clk);
      latency = txrx_latency;
      for (i = 0; i < 8; i++) begin
         wait_rx_valid(1, "latency frame");
         repeat (2) @(negedge lb_clk);
         checks++;
         assert (txrx_latency == latency && latency != 0 && latency <= MAX_LATENCY)
         else count_error($sformatf("latency %0d, settled at %0d", txrx_latency, latency));
      end
      report_test("loopback latency", mark);

      $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

//--- build.f
common/chitchat_proto_pkg.sv
common/chitchat_status_pkg.sv
rtl/data_xdomain.sv
chitchat_tx/chitchat_tx.sv
chitchat_rx/chitchat_rx.sv
rtl/chitchat_txrx_wrap.sv
verification/chitchat_tb.sv

//--- Bender.yml
package:
  name: chitchat

sources:
  - files:
      - common/chitchat_proto_pkg.sv
      - common/chitchat_status_pkg.sv
      - rtl/data_xdomain.sv
      - chitchat_tx/chitchat_tx.sv
      - chitchat_rx/chitchat_rx.sv
      - rtl/chitchat_txrx_wrap.sv
  - target: test
    files:
      - verification/chitchat_tb.sv
